// File: logic/mailbox_map_pkg.sv
/*
 * Mailbox address map
 * widths, register windows and fixed data values shared by the
 * ingress, register file, completion and top level
 */
`default_nettype none

package mailbox_map_pkg;

    // ----------------------------------------
    // port widths
    // ----------------------------------------
    localparam int ADDR_W = 15;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    // ----------------------------------------
    // register windows, byte addresses
    // ----------------------------------------
    localparam logic [ADDR_W-1:0] MB_FIRST = 15'h2000;
    localparam logic [ADDR_W-1:0] MB_LAST  = 15'h201F;
    localparam logic [ADDR_W-1:0] AA_FIRST = 15'h2100;
    localparam logic [ADDR_W-1:0] AA_LAST  = 15'h2107;

    localparam int MB_WORDS = 8;
    localparam int AA_WORDS = 2;
    // word index taken from address bits above the byte offset
    localparam int IDX_W    = 3;

    // aux words
    localparam int AA_ENABLE_WORD = 0;
    localparam int AA_STATUS_WORD = 1;

    // returned for any read outside MB and AA
    localparam logic [DATA_W-1:0] READ_ALL_ONES = '1;

    // ----------------------------------------
    // stream header beat layout
    // ----------------------------------------
    localparam int SS_ADDR_W   = 28;
    localparam int SS_STRB_LSB = 28;
    localparam int SS_USER_W   = 2;

endpackage

`default_nettype wire

// File: logic/mailbox_cmd_pkg.sv
/*
 * Mailbox command types
 * opcodes passed from ingress to the register file and the
 * stream user codes seen on the SS port
 */
`default_nettype none

package mailbox_cmd_pkg;

    import mailbox_map_pkg::*;

    // one decoded operation per command handshake
    typedef enum logic [2:0] {
        OP_WR_MB,
        OP_RD_MB,
        OP_WR_AA,
        OP_RD_AA,
        OP_RD_UNSUPP,
        // acked, nothing written
        OP_WR_IGNORE,
        // stream write, also sets interrupt status
        OP_REMOTE_WR_MB
    } mailbox_op_e;

    // user field of the first stream beat
    typedef enum logic [SS_USER_W-1:0] {
        SS_RESERVED   = 2'b00,
        SS_REMOTE_WR  = 2'b01,
        // remote read request, not served here
        SS_REMOTE_RD  = 2'b10,
        // read return, not served here
        SS_RD_RETURN  = 2'b11
    } ss_user_e;

endpackage

`default_nettype wire

// File: logic/mailbox_cmd_if.sv
/*
 * Mailbox command channel
 * one decoded command with a four-phase req/ack between
 * ingress (issuer) and register file (executor)
 */
`timescale 1ns/10ps
`default_nettype none

interface mailbox_cmd_if
    import mailbox_map_pkg::*;
    import mailbox_cmd_pkg::*;
();

    logic              req;
    logic              ack;
    mailbox_op_e       op;
    logic [IDX_W-1:0]  index;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;

    // fields are stable for the whole time req is high
    modport issuer (
        output req, op, index, wdata, wstrb,
        input  ack
    );

    modport executor (
        input  req, op, index, wdata, wstrb,
        output ack
    );

endinterface

`default_nettype wire

// File: logic/mailbox_ingress.sv
/*
 * Mailbox ingress
 * round-robin between LS and SS, collects the two stream beats,
 * decodes addresses and issues one command at a time
 */
`timescale 1ns/10ps
`default_nettype none

module mailbox_ingress
    import mailbox_map_pkg::*;
    import mailbox_cmd_pkg::*;
(
    input  wire                 axi_aclk,
    input  wire                 axi_aresetn,
    input  wire                 bk_ls_valid,
    input  wire                 bk_ls_rd_wr,
    input  wire  [ADDR_W-1:0]   bk_ls_addr,
    input  wire  [DATA_W-1:0]   bk_ls_wdata,
    input  wire  [STRB_W-1:0]   bk_ls_wstrb,
    input  wire                 bk_ss_valid,
    input  wire  [DATA_W-1:0]   bk_ss_data,
    input  wire  [SS_USER_W-1:0] bk_ss_user,
    output logic                bk_ss_ready,
    mailbox_cmd_if.issuer       cmd
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_GRANT,
        ST_LS_ISSUE,
        ST_SS_HDR,
        ST_SS_DATA,
        ST_WAIT_ACK,
        ST_WAIT_REL
    } state_e;

    state_e               state;
    logic                 grant_ss;
    logic                 last_ss;
    logic                 ss_ready;
    logic                 ss_beat;
    logic                 ls_in_mb;
    logic                 ls_in_aa;
    logic                 hdr_in_mb;
    mailbox_op_e          ls_op;
    logic [SS_ADDR_W-1:0] hdr_addr;
    logic [STRB_W-1:0]    hdr_strb;

    assign ss_beat     = bk_ss_valid && ss_ready;
    assign bk_ss_ready = ss_ready;
    // req covers the issue cycle and the wait for ack
    assign cmd.req     = (state == ST_LS_ISSUE) || (state == ST_WAIT_ACK);

    // ----------------------------------------
    // address decode
    // ----------------------------------------
    assign ls_in_mb  = (bk_ls_addr >= MB_FIRST) && (bk_ls_addr <= MB_LAST);
    assign ls_in_aa  = (bk_ls_addr >= AA_FIRST) && (bk_ls_addr <= AA_LAST);
    assign hdr_in_mb = (hdr_addr >= SS_ADDR_W'(MB_FIRST)) &&
                       (hdr_addr <= SS_ADDR_W'(MB_LAST));

    // rd_wr high means read
    always_comb begin
        if (ls_in_mb) begin
            ls_op = bk_ls_rd_wr ? OP_RD_MB : OP_WR_MB;
        end else if (ls_in_aa) begin
            ls_op = bk_ls_rd_wr ? OP_RD_AA : OP_WR_AA;
        end else begin
            ls_op = bk_ls_rd_wr ? OP_RD_UNSUPP : OP_WR_IGNORE;
        end
    end

    // ----------------------------------------
    // control FSM
    // ----------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state    <= ST_IDLE;
            grant_ss <= 1'b0;
            // LS takes the first tie after reset
            last_ss  <= 1'b1;
            ss_ready <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (bk_ls_valid || bk_ss_valid) begin
                        grant_ss <= bk_ss_valid && (!bk_ls_valid || !last_ss);
                        state    <= ST_GRANT;
                    end
                end
                ST_GRANT: begin
                    last_ss <= grant_ss;
                    state   <= grant_ss ? ST_SS_HDR : ST_LS_ISSUE;
                end
                ST_LS_ISSUE: begin
                    state <= ST_WAIT_ACK;
                end
                ST_SS_HDR: begin
                    if (ss_beat) begin
                        ss_ready <= 1'b0;
                        // only remote writes carry a data beat
                        if (ss_user_e'(bk_ss_user) == SS_REMOTE_WR) begin
                            state <= ST_SS_DATA;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end else if (bk_ss_valid) begin
                        ss_ready <= 1'b1;
                    end
                end
                ST_SS_DATA: begin
                    if (ss_beat) begin
                        ss_ready <= 1'b0;
                        state    <= hdr_in_mb ? ST_WAIT_ACK : ST_IDLE;
                    end else if (bk_ss_valid) begin
                        ss_ready <= 1'b1;
                    end
                end
                ST_WAIT_ACK: begin
                    if (cmd.ack) begin
                        state <= ST_WAIT_REL;
                    end
                end
                ST_WAIT_REL: begin
                    if (!cmd.ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // command fields and stream header
    always_ff @(posedge axi_aclk) begin
        if (state == ST_GRANT && !grant_ss) begin
            cmd.op    <= ls_op;
            cmd.index <= bk_ls_addr[IDX_W+1:2];
            cmd.wdata <= bk_ls_wdata;
            cmd.wstrb <= bk_ls_wstrb;
        end else if (state == ST_SS_DATA && ss_beat) begin
            cmd.op    <= OP_REMOTE_WR_MB;
            cmd.index <= hdr_addr[IDX_W+1:2];
            cmd.wdata <= bk_ss_data;
            cmd.wstrb <= hdr_strb;
        end
        if (state == ST_SS_HDR && ss_beat) begin
            hdr_addr <= bk_ss_data[SS_ADDR_W-1:0];
            hdr_strb <= bk_ss_data[SS_STRB_LSB +: STRB_W];
        end
    end

    // req is only released after the executor answered
    a_req_held: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        $fell(cmd.req) |-> $past(cmd.ack));

    a_ss_ready_state: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        bk_ss_ready |-> (state inside {ST_SS_HDR, ST_SS_DATA}));

endmodule

`default_nettype wire

// File: logic/mailbox_regfile.sv
/*
 * Mailbox register file
 * eight mailbox words plus interrupt enable and status, executes
 * commands from ingress and drives the interrupt
 */
`timescale 1ns/10ps
`default_nettype none

module mailbox_regfile
    import mailbox_map_pkg::*;
    import mailbox_cmd_pkg::*;
(
    input  wire                axi_aclk,
    input  wire                axi_aresetn,
    mailbox_cmd_if.executor    cmd,
    output logic               ls_done,
    output logic [DATA_W-1:0]  ls_rdata,
    output logic               axi_interrupt
);

    logic [DATA_W-1:0] mb_regs [MB_WORDS];
    logic              int_en;
    logic              int_status;
    logic              req_q;
    logic              ack;
    logic              exec;
    logic [DATA_W-1:0] rd_word;

    // one execute per handshake on the cycle after req was sampled
    assign exec          = req_q && cmd.req && !ack;
    assign cmd.ack       = ack;
    assign axi_interrupt = int_en && int_status;

    // read mux gives zero for every write opcode
    always_comb begin
        rd_word = '0;
        case (cmd.op)
            OP_RD_MB: begin
                rd_word = mb_regs[cmd.index];
            end
            OP_RD_AA: begin
                if (cmd.index == IDX_W'(AA_ENABLE_WORD)) begin
                    rd_word[0] = int_en;
                end else if (cmd.index == IDX_W'(AA_STATUS_WORD)) begin
                    rd_word[0] = int_status;
                end
            end
            OP_RD_UNSUPP: begin
                rd_word = READ_ALL_ONES;
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    // ----------------------------------------
    // handshake and register writes
    // ----------------------------------------
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            req_q      <= 1'b0;
            ack        <= 1'b0;
            ls_done    <= 1'b0;
            int_en     <= 1'b0;
            int_status <= 1'b0;
            for (int w = 0; w < MB_WORDS; w++) begin
                mb_regs[w] <= '0;
            end
        end else begin
            req_q   <= cmd.req;
            ls_done <= 1'b0;
            if (exec) begin
                ack     <= 1'b1;
                ls_done <= (cmd.op != OP_REMOTE_WR_MB);
                case (cmd.op)
                    OP_WR_MB, OP_REMOTE_WR_MB: begin
                        for (int b = 0; b < STRB_W; b++) begin
                            if (cmd.wstrb[b]) begin
                                mb_regs[cmd.index][b*8 +: 8] <= cmd.wdata[b*8 +: 8];
                            end
                        end
                    end
                    OP_WR_AA: begin
                        // only bit 0 of each aux word is writable
                        if (cmd.wstrb[0]) begin
                            if (cmd.index == IDX_W'(AA_ENABLE_WORD)) begin
                                int_en <= cmd.wdata[0];
                            end else if (cmd.index == IDX_W'(AA_STATUS_WORD) &&
                                         cmd.wdata[0]) begin
                                int_status <= 1'b0;
                            end
                        end
                    end
                    default: begin
                    end
                endcase
                // set even with interrupt disabled
                if (cmd.op == OP_REMOTE_WR_MB) begin
                    int_status <= 1'b1;
                end
            end else if (ack && !cmd.req) begin
                ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (exec) begin
            ls_rdata <= rd_word;
        end
    end

    a_ack_needs_req: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        $rose(cmd.ack) |-> (cmd.req && $past(cmd.req)));

endmodule

`default_nettype wire

// File: logic/mailbox_completion.sv
/*
 * Mailbox completion
 * turns the register file done pulse into the LS ready pulse
 * with its read data
 */
`timescale 1ns/10ps
`default_nettype none

module mailbox_completion
    import mailbox_map_pkg::*;
(
    input  wire                axi_aclk,
    input  wire                axi_aresetn,
    input  wire                ls_done,
    input  wire  [DATA_W-1:0]  ls_rdata,
    output logic               bk_ls_ready,
    output logic [DATA_W-1:0]  bk_ls_rdata
);

    // ready follows done by one cycle, rdata only valid with it
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            bk_ls_ready <= 1'b0;
            bk_ls_rdata <= '0;
        end else begin
            bk_ls_ready <= ls_done;
            if (ls_done) begin
                bk_ls_rdata <= ls_rdata;
            end else begin
                // back to zero once the pulse is over
                bk_ls_rdata <= '0;
            end
        end
    end

    // done is a single pulse per LS command
    a_ready_pulse: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        bk_ls_ready |=> !bk_ls_ready);

endmodule

`default_nettype wire

// File: logic/axi_ctrl_logic.sv
/*
 * Mailbox and interrupt controller, top level
 * LS register port and SS stream port into the mailbox
 */
`timescale 1ns/10ps
`default_nettype none

module axi_ctrl_logic
    import mailbox_map_pkg::*;
(
    input  wire                  axi_aclk,
    input  wire                  axi_aresetn,
    output logic                 axi_interrupt,

    // LS register access
    input  wire                  bk_ls_rd_wr,
    input  wire  [ADDR_W-1:0]    bk_ls_addr,
    input  wire  [DATA_W-1:0]    bk_ls_wdata,
    input  wire  [STRB_W-1:0]    bk_ls_wstrb,
    output logic [DATA_W-1:0]    bk_ls_rdata,
    input  wire                  bk_ls_valid,
    output logic                 bk_ls_ready,

    // SS stream input
    input  wire  [DATA_W-1:0]    bk_ss_data,
    input  wire  [SS_USER_W-1:0] bk_ss_user,
    output logic                 bk_ss_ready,
    input  wire                  bk_ss_valid
);

    logic              ls_done;
    logic [DATA_W-1:0] ls_rdata;

    mailbox_cmd_if cmd_if ();

    mailbox_ingress ingress_i (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .bk_ls_valid (bk_ls_valid),
        .bk_ls_rd_wr (bk_ls_rd_wr),
        .bk_ls_addr  (bk_ls_addr),
        .bk_ls_wdata (bk_ls_wdata),
        .bk_ls_wstrb (bk_ls_wstrb),
        .bk_ss_valid (bk_ss_valid),
        .bk_ss_data  (bk_ss_data),
        .bk_ss_user  (bk_ss_user),
        .bk_ss_ready (bk_ss_ready),
        .cmd         (cmd_if.issuer)
    );

    mailbox_regfile regfile_i (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .cmd           (cmd_if.executor),
        .ls_done       (ls_done),
        .ls_rdata      (ls_rdata),
        .axi_interrupt (axi_interrupt)
    );

    mailbox_completion completion_i (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .ls_done     (ls_done),
        .ls_rdata    (ls_rdata),
        .bk_ls_ready (bk_ls_ready),
        .bk_ls_rdata (bk_ls_rdata)
    );

endmodule

`default_nettype wire

// File: verification/tb_axi_ctrl_logic.sv
/*
 * Testbench for the mailbox and interrupt controller
 * LFSR driven LS and SS traffic, a shadow register model and
 * assertions on read data, interrupt and arbitration order
 */
`timescale 1ns/10ps
`default_nettype none

module tb_axi_ctrl_logic
    import mailbox_map_pkg::*;
();

    logic                 axi_aclk;
    logic                 axi_aresetn;
    logic                 axi_interrupt;
    logic                 bk_ls_rd_wr;
    logic [ADDR_W-1:0]    bk_ls_addr;
    logic [DATA_W-1:0]    bk_ls_wdata;
    logic [STRB_W-1:0]    bk_ls_wstrb;
    logic [DATA_W-1:0]    bk_ls_rdata;
    logic                 bk_ls_valid;
    logic                 bk_ls_ready;
    logic [DATA_W-1:0]    bk_ss_data;
    logic [SS_USER_W-1:0] bk_ss_user;
    logic                 bk_ss_ready;
    logic                 bk_ss_valid;

    // shadow of the register state
    logic [DATA_W-1:0]    model_mb [MB_WORDS];
    logic                 model_en;
    logic                 model_status;
    logic [DATA_W-1:0]    exp_rdata;
    logic [15:0]          lfsr;
    int                   wait_limit = 64;

    axi_ctrl_logic dut_i (.*);

    initial begin
        axi_aclk = 1'b0;
        forever #4 axi_aclk = ~axi_aclk;
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    // taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [DATA_W-1:0] rand_bits(int n);
        logic [DATA_W-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[DATA_W-2:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic in_mb(logic [ADDR_W-1:0] a);
        return (a >= MB_FIRST) && (a <= MB_LAST);
    endfunction

    function automatic logic in_aa(logic [ADDR_W-1:0] a);
        return (a >= AA_FIRST) && (a <= AA_LAST);
    endfunction

    function automatic logic [DATA_W-1:0] expected_read(logic [ADDR_W-1:0] a);
        if (in_mb(a)) begin
            return model_mb[a[4:2]];
        end else if (in_aa(a)) begin
            // bit 2 picks enable or status word
            return {{(DATA_W-1){1'b0}}, (a[2] ? model_status : model_en)};
        end
        return READ_ALL_ONES;
    endfunction

    function automatic void merge_word(logic [IDX_W-1:0] i, logic [DATA_W-1:0] d,
                                       logic [STRB_W-1:0] s);
        for (int b = 0; b < STRB_W; b++) begin
            if (s[b]) begin
                model_mb[i][b*8 +: 8] = d[b*8 +: 8];
            end
        end
    endfunction

    // ----------------------------------------
    // LS master
    // ----------------------------------------
    task automatic ls_access(logic rd_wr, logic [ADDR_W-1:0] a, logic [DATA_W-1:0] d,
                             logic [STRB_W-1:0] s);
        int n;
        n           = 0;
        exp_rdata   = rd_wr ? expected_read(a) : '0;
        bk_ls_rd_wr = rd_wr;
        bk_ls_addr  = a;
        bk_ls_wdata = d;
        bk_ls_wstrb = s;
        bk_ls_valid = 1'b1;
        do begin
            @(posedge axi_aclk);
            #1;
            n++;
        end while (!bk_ls_ready && n < wait_limit);
        if (!bk_ls_ready) begin
            abort_run($sformatf("timeout waiting for bk_ls_ready at address %h", a));
        end
        bk_ls_valid = 1'b0;
        assert (axi_interrupt == (model_en && model_status)) else
            abort_run($sformatf("MISMATCH at %0t: axi_interrupt %b, expected %b",
                                $time, axi_interrupt, model_en && model_status));
        @(posedge axi_aclk);
        #1;
    endtask

    task automatic ls_write(logic [ADDR_W-1:0] a, logic [DATA_W-1:0] d, logic [STRB_W-1:0] s);
        if (in_mb(a)) begin
            merge_word(a[4:2], d, s);
        end else if (in_aa(a) && s[0]) begin
            if (!a[2]) begin
                model_en = d[0];
            end else if (d[0]) begin
                model_status = 1'b0;
            end
        end
        ls_access(1'b0, a, d, s);
    endtask

    task automatic ls_read(logic [ADDR_W-1:0] a);
        ls_access(1'b1, a, '0, '0);
    endtask

    task automatic read_all_mb();
        for (int w = 0; w < MB_WORDS; w++) begin
            ls_read(MB_FIRST + ADDR_W'(w * 4));
        end
    endtask

    // ----------------------------------------
    // SS source
    // ----------------------------------------
    task automatic ss_beat(logic [SS_USER_W-1:0] user, logic [DATA_W-1:0] d);
        int n;
        n           = 0;
        bk_ss_user  = user;
        bk_ss_data  = d;
        bk_ss_valid = 1'b1;
        do begin
            @(posedge axi_aclk);
            #1;
            n++;
        end while (!bk_ss_ready && n < wait_limit);
        if (!bk_ss_ready) begin
            abort_run("timeout waiting for bk_ss_ready");
        end
        // beat moves on the next edge
        @(posedge axi_aclk);
        #1;
        bk_ss_valid = 1'b0;
    endtask

    task automatic ss_packet(logic [SS_USER_W-1:0] user, logic [SS_ADDR_W-1:0] a,
                             logic [STRB_W-1:0] s, logic [DATA_W-1:0] d);
        ss_beat(user, {s, a});
        if (user == 2'b01) begin
            ss_beat(user, d);
            if (a >= SS_ADDR_W'(MB_FIRST) && a <= SS_ADDR_W'(MB_LAST)) begin
                merge_word(a[4:2], d, s);
                model_status = 1'b1;
            end
        end
        @(posedge axi_aclk);
        #1;
    endtask

    // LS and SS valid together, LS must finish first
    task automatic tie_after_reset();
        int n;
        n = 0;
        exp_rdata   = expected_read(MB_FIRST);
        bk_ls_rd_wr = 1'b1;
        bk_ls_addr  = MB_FIRST;
        bk_ls_valid = 1'b1;
        bk_ss_user  = 2'b01;
        bk_ss_data  = {4'hF, 28'h200C};
        bk_ss_valid = 1'b1;
        do begin
            @(posedge axi_aclk);
            #1;
            n++;
            assert (!bk_ss_ready) else
                abort_run("bk_ss_ready came before bk_ls_ready on the first tie");
        end while (!bk_ls_ready && n < wait_limit);
        if (!bk_ls_ready) begin
            abort_run("timeout waiting for bk_ls_ready on the first tie");
        end
        bk_ls_valid = 1'b0;
        ss_packet(2'b01, 28'h200C, 4'hF, rand_bits(DATA_W));
    endtask

    a_ls_rdata: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        bk_ls_ready |-> (bk_ls_rdata == exp_rdata))
        else abort_run($sformatf("MISMATCH at %0t: LS read data %h, expected %h",
                                 $time, $sampled(bk_ls_rdata), $sampled(exp_rdata)));

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        logic [ADDR_W-1:0] addr;
        lfsr         = 16'd76;
        model_en     = 1'b0;
        model_status = 1'b0;
        exp_rdata    = '0;
        for (int w = 0; w < MB_WORDS; w++) begin
            model_mb[w] = '0;
        end
        axi_aresetn = 1'b0;
        bk_ls_rd_wr = 1'b0;
        bk_ls_addr  = '0;
        bk_ls_wdata = '0;
        bk_ls_wstrb = '0;
        bk_ls_valid = 1'b0;
        bk_ss_data  = '0;
        bk_ss_user  = '0;
        bk_ss_valid = 1'b0;
        repeat (8) @(posedge axi_aclk);
        #1;
        axi_aresetn = 1'b1;
        @(posedge axi_aclk);
        #1;

        tie_after_reset();

        // byte merge on every mailbox word
        for (int w = 0; w < MB_WORDS; w++) begin
            addr = MB_FIRST + ADDR_W'(w * 4) + ADDR_W'(rand_bits(2));
            ls_write(addr, rand_bits(DATA_W), STRB_W'(rand_bits(STRB_W)));
            ls_read(addr);
        end

        // unmapped space
        ls_read(15'h2020);
        ls_read(15'h3000);
        ls_read(15'h2108);
        ls_write(15'h2020, rand_bits(DATA_W), 4'hF);
        ls_write(15'h3000, rand_bits(DATA_W), 4'hF);
        read_all_mb();

        // enable, status and the interrupt
        ls_write(AA_FIRST, 32'hFFFF_FFFF, 4'hF);
        ls_read(AA_FIRST);
        ls_read(AA_FIRST + 15'd4);
        ls_write(AA_FIRST + 15'd4, 32'h0000_0001, 4'h1);
        ls_read(AA_FIRST + 15'd4);
        for (int k = 0; k < 4; k++) begin
            ss_packet(2'b01, SS_ADDR_W'(MB_FIRST) + SS_ADDR_W'(rand_bits(5)),
                      STRB_W'(rand_bits(STRB_W)), rand_bits(DATA_W));
            read_all_mb();
            ls_read(AA_FIRST + 15'd4);
        end
        // strobe 0 off leaves enable alone
        ls_write(AA_FIRST, 32'h0, 4'hE);
        ls_write(AA_FIRST, 32'h0, 4'h1);
        ls_write(AA_FIRST, 32'h1, 4'h1);
        ls_write(AA_FIRST + 15'd4, 32'h0000_0001, 4'hF);

        // packets that must change nothing
        ss_packet(2'b00, 28'h2000, 4'hF, rand_bits(DATA_W));
        ss_packet(2'b10, 28'h2004, 4'hF, rand_bits(DATA_W));
        ss_packet(2'b11, 28'h2008, 4'hF, rand_bits(DATA_W));
        ss_packet(2'b01, 28'h3000, 4'hF, rand_bits(DATA_W));
        ss_packet(2'b01, 28'h2100, 4'hF, rand_bits(DATA_W));
        ss_packet(2'b01, 28'h0012000, 4'hF, rand_bits(DATA_W));
        read_all_mb();
        ls_read(AA_FIRST + 15'd4);
        ls_read(AA_FIRST);

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
logic/mailbox_map_pkg.sv
logic/mailbox_cmd_pkg.sv
logic/mailbox_cmd_if.sv
logic/mailbox_ingress.sv
logic/mailbox_regfile.sv
logic/mailbox_completion.sv
logic/axi_ctrl_logic.sv
verification/tb_axi_ctrl_logic.sv

// File: run_sim.sh
#!/bin/sh
# build the mailbox testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/10ps -f flist.f \
    --top-module tb_axi_ctrl_logic -o tb_axi_ctrl_logic &&
    ./obj_dir/tb_axi_ctrl_logic > sim.log 2>&1 ||
    echo "build or simulation returned an error"

grep -qsx "sim passed" sim.log && echo "PASS" && exit 0 ||
    { echo "FAIL, see sim.log"; exit 1; }
